/* sb_pkg.sv */
`default_nettype none

package sb_pkg;

    localparam int NUM_REGS   = 16;
    localparam int REG_W      = 4;
    localparam int INSTR_W    = 32;
    localparam int IMM_W      = 16;
    // widest datapath the shared result bus can carry, narrower data sits in the low bits
    localparam int DATA_W_MAX = 32;

    typedef logic [REG_W-1:0] reg_idx_t;

    // encodings follow the 4-bit opcode field, anything above OP_MUL is a NOP
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_SLL  = 4'd6,
        OP_ADDI = 4'd7,
        OP_MUL  = 4'd8
    } opcode_t;

    // issue target and producer tag share one encoding
    typedef enum logic [1:0] {
        FU_NONE = 2'd0,
        FU_ALU  = 2'd1,
        FU_MUL  = 2'd2
    } fu_t;

    typedef struct packed {
        opcode_t          op;
        fu_t              fu;
        reg_idx_t         rd;
        reg_idx_t         rs1;
        reg_idx_t         rs2;
        logic [IMM_W-1:0] imm;
        logic             reg_write;
        logic             use_imm;
    } decoded_t;

    // contents of one reservation row
    typedef struct packed {
        opcode_t          op;
        reg_idx_t         rd;
        reg_idx_t         rs1;
        reg_idx_t         rs2;
        logic [IMM_W-1:0] imm;
        logic             use_imm;
        logic             reg_write;
        fu_t              t1;
        fu_t              t2;
    } fu_req_t;

    typedef struct packed {
        logic busy;
        fu_t  tag;
    } reg_status_t;

    typedef struct packed {
        logic                  en;
        fu_t                   tag;
        reg_idx_t              rd;
        logic [DATA_W_MAX-1:0] data;
    } wb_t;

endpackage

`default_nettype wire

/* sb_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module sb_decode import sb_pkg::*; (
    input  logic [INSTR_W-1:0] instr,
    output decoded_t           dec
);

    logic [3:0] op_bits;

    assign op_bits = instr[31:28];

    always_comb begin
        dec = '0;

        // unlisted opcodes fall back to a NOP
        if (op_bits <= 4'(OP_MUL)) begin
            dec.op = opcode_t'(op_bits);
        end else begin
            dec.op = OP_NOP;
        end

        case (dec.op)
            OP_NOP:  dec.fu = FU_NONE;
            OP_MUL:  dec.fu = FU_MUL;
            default: dec.fu = FU_ALU;
        endcase

        dec.rd  = instr[27:24];
        dec.rs1 = instr[23:20];
        dec.rs2 = instr[19:16];
        // kept at 16 bits, sign extended to the datapath width inside the units
        dec.imm = instr[15:0];

        dec.use_imm   = (dec.op == OP_ADDI);
        // r0 is hardwired, so a write to it never claims the register
        dec.reg_write = (dec.op != OP_NOP) && (dec.rd != '0);
    end

endmodule

`default_nettype wire

/* sb_reg_status.sv */
`timescale 1ns/10ps
`default_nettype none

module sb_reg_status import sb_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        set_en,
    input  reg_idx_t    set_rd,
    input  fu_t         set_tag,
    input  wb_t         wb,
    input  reg_idx_t    rd,
    input  reg_idx_t    rs1,
    input  reg_idx_t    rs2,
    output reg_status_t st_rd,
    output reg_status_t st_rs1,
    output reg_status_t st_rs2
);

    reg_status_t status [NUM_REGS];

    // entry as seen after this cycle's writeback
    function automatic reg_status_t lookup(input reg_idx_t idx);
        reg_status_t st;
        st = status[idx];
        if (wb.en && (wb.rd == idx) && (wb.tag == st.tag)) begin
            st = '0;
        end
        return st;
    endfunction

    always_comb begin
        st_rd  = lookup(rd);
        st_rs1 = lookup(rs1);
        st_rs2 = lookup(rs2);
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                status[i] <= '0;
            end
        end else begin
            // retire only if the writer is still the recorded producer
            if (wb.en && (status[wb.rd].tag == wb.tag)) begin
                status[wb.rd] <= '0;
            end
            // a new claim on the same register wins over the clear
            if (set_en) begin
                status[set_rd].busy <= 1'b1;
                status[set_rd].tag  <= set_tag;
            end
        end
    end

endmodule

`default_nettype wire

/* sb_dispatch.sv */
`timescale 1ns/10ps
`default_nettype none

module sb_dispatch import sb_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic        instr_valid,
    input  decoded_t    dec,
    input  reg_status_t st_rd,
    input  reg_status_t st_rs1,
    input  reg_status_t st_rs2,
    input  logic        alu_busy,
    input  logic        mul_busy,
    output logic        stall,
    output logic        alu_issue,
    output logic        mul_issue,
    output fu_req_t     req,
    output logic        set_en,
    output reg_idx_t    set_rd,
    output fu_t         set_tag
);

    logic unit_busy;
    logic waw;
    logic hazard;
    logic accept;

    // the result bus only has room for DATA_W_MAX data bits
    if ((DATA_W < 1) || (DATA_W > DATA_W_MAX)) begin : g_width_check
        $error("sb_dispatch: DATA_W %0d outside 1..%0d", DATA_W, DATA_W_MAX);
    end

    always_comb begin
        case (dec.fu)
            FU_ALU:  unit_busy = alu_busy;
            FU_MUL:  unit_busy = mul_busy;
            default: unit_busy = 1'b0;
        endcase
    end

    // only one writer per register may be in flight
    assign waw    = dec.reg_write && st_rd.busy;
    assign hazard = unit_busy || waw;

    assign stall  = instr_valid && hazard;
    assign accept = instr_valid && !hazard;

    // a NOP is consumed here and never reaches a unit
    assign alu_issue = accept && (dec.fu == FU_ALU);
    assign mul_issue = accept && (dec.fu == FU_MUL);

    always_comb begin
        req.op        = dec.op;
        req.rd        = dec.rd;
        req.rs1       = dec.rs1;
        req.rs2       = dec.rs2;
        req.imm       = dec.imm;
        req.use_imm   = dec.use_imm;
        req.reg_write = dec.reg_write;
        // status lookup already reports FU_NONE for anything not pending
        req.t1        = st_rs1.tag;
        req.t2        = dec.use_imm ? FU_NONE : st_rs2.tag;
    end

    assign set_en  = accept && dec.reg_write;
    assign set_rd  = dec.rd;
    assign set_tag = dec.fu;

endmodule

`default_nettype wire

/* sb_fu_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module sb_fu_alu import sb_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              issue,
    input  fu_req_t           req,
    input  wb_t               wb,
    input  logic              ack,
    input  logic [DATA_W-1:0] op_a,
    input  logic [DATA_W-1:0] op_b,
    output reg_idx_t          rs1,
    output reg_idx_t          rs2,
    output logic              busy,
    output wb_t               result
);

    localparam int SH_W = (DATA_W > 1) ? $clog2(DATA_W) : 1;

    fu_req_t           row;
    logic              busy_q;
    logic              done_q;
    logic              t1_clear;
    logic              t2_clear;
    logic              ready;
    logic [DATA_W-1:0] imm_ext;
    logic [DATA_W-1:0] src_b;
    logic [DATA_W-1:0] alu_out;
    logic [DATA_W-1:0] res_q;

    // tags count as clear when the producer broadcasts in this same cycle
    assign t1_clear = (row.t1 == FU_NONE) || (wb.en && (wb.tag == row.t1));
    assign t2_clear = (row.t2 == FU_NONE) || (wb.en && (wb.tag == row.t2));
    assign ready    = busy_q && !done_q && t1_clear && t2_clear;

    assign rs1  = row.rs1;
    assign rs2  = row.rs2;
    assign busy = busy_q;

    assign imm_ext = DATA_W'($signed(row.imm));
    assign src_b   = row.use_imm ? imm_ext : op_b;

    always_comb begin
        case (row.op)
            OP_SUB:  alu_out = op_a - src_b;
            OP_AND:  alu_out = op_a & src_b;
            OP_OR:   alu_out = op_a | src_b;
            OP_XOR:  alu_out = op_a ^ src_b;
            OP_SLL:  alu_out = op_a << src_b[SH_W-1:0];
            default: alu_out = op_a + src_b;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (issue) begin
            row <= req;
        end else begin
            if (t1_clear) begin
                row.t1 <= FU_NONE;
            end
            if (t2_clear) begin
                row.t2 <= FU_NONE;
            end
        end
        if (ready) begin
            res_q <= alu_out;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (issue) begin
            busy_q <= 1'b1;
            done_q <= 1'b0;
        end else if (done_q && ack) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (ready) begin
            // an r0 destination frees the row without offering a result
            busy_q <= row.reg_write;
            done_q <= row.reg_write;
        end
    end

    always_comb begin
        result      = '0;
        result.en   = done_q;
        result.tag  = FU_ALU;
        result.rd   = row.rd;
        result.data = DATA_W_MAX'(res_q);
    end

endmodule

`default_nettype wire

/* sb_fu_mul.sv */
`timescale 1ns/10ps
`default_nettype none

module sb_fu_mul import sb_pkg::*; #(
    parameter int DATA_W     = 32,
    parameter int MUL_CYCLES = 4
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              issue,
    input  fu_req_t           req,
    input  wb_t               wb,
    input  logic              ack,
    input  logic [DATA_W-1:0] op_a,
    input  logic [DATA_W-1:0] op_b,
    output reg_idx_t          rs1,
    output reg_idx_t          rs2,
    output logic              busy,
    output wb_t               result
);

    localparam int CNT_W = $clog2(MUL_CYCLES);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_OPS,
        EXEC,
        DONE
    } state_t;

    state_t            state;
    fu_req_t           row;
    logic [CNT_W-1:0]  cnt;
    logic              t1_clear;
    logic              t2_clear;
    logic              ready;
    logic [DATA_W-1:0] a_q;
    logic [DATA_W-1:0] b_q;
    logic [DATA_W-1:0] prod_q;

    assign t1_clear = (row.t1 == FU_NONE) || (wb.en && (wb.tag == row.t1));
    assign t2_clear = (row.t2 == FU_NONE) || (wb.en && (wb.tag == row.t2));
    assign ready    = (state == WAIT_OPS) && t1_clear && t2_clear;

    assign rs1  = row.rs1;
    assign rs2  = row.rs2;
    assign busy = (state != IDLE);

    always_ff @(posedge CLK) begin
        if (issue) begin
            row <= req;
        end else begin
            if (t1_clear) begin
                row.t1 <= FU_NONE;
            end
            if (t2_clear) begin
                row.t2 <= FU_NONE;
            end
        end
        // capture operands once, then multiply on the last count
        if (ready) begin
            a_q <= op_a;
            b_q <= op_b;
        end
        if ((state == EXEC) && (cnt == CNT_W'(1))) begin
            prod_q <= a_q * b_q;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (issue) begin
                        state <= WAIT_OPS;
                    end
                end
                WAIT_OPS: begin
                    if (ready) begin
                        // nothing to compute for an r0 destination
                        state <= row.reg_write ? EXEC : IDLE;
                        cnt   <= CNT_W'(MUL_CYCLES - 1);
                    end
                end
                EXEC: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == CNT_W'(1)) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    if (ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_comb begin
        result      = '0;
        result.en   = (state == DONE);
        result.tag  = FU_MUL;
        result.rd   = row.rd;
        result.data = DATA_W_MAX'(prod_q);
    end

endmodule

`default_nettype wire

/* sb_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module sb_regfile import sb_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic              CLK,
    input  logic              nRST,
    input  reg_idx_t          raddr [4],
    output logic [DATA_W-1:0] rdata [4],
    input  wb_t               wb
);

    logic [DATA_W-1:0] regs [NUM_REGS];
    logic              wr_en;

    assign wr_en = wb.en && (wb.rd != '0);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.data[DATA_W-1:0];
        end
    end

    // write-through so a waiting unit sees the value being retired this cycle
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (raddr[p] == '0) begin
                rdata[p] = '0;
            end else if (wr_en && (wb.rd == raddr[p])) begin
                rdata[p] = wb.data[DATA_W-1:0];
            end else begin
                rdata[p] = regs[raddr[p]];
            end
        end
    end

endmodule

`default_nettype wire

/* sb_writeback.sv */
`timescale 1ns/10ps
`default_nettype none

module sb_writeback import sb_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  wb_t  alu_res,
    input  wb_t  mul_res,
    output logic alu_ack,
    output logic mul_ack,
    output wb_t  wb
);

    wb_t sel;

    // multiplier first, the ALU is cheaper to hold back
    assign mul_ack = mul_res.en;
    assign alu_ack = alu_res.en && !mul_res.en;

    always_comb begin
        if (mul_ack) begin
            sel = mul_res;
        end else if (alu_ack) begin
            sel = alu_res;
        end else begin
            sel = '0;
        end
    end

    // bits above DATA_W are forced to zero on the broadcast
    always_comb begin
        wb      = sel;
        wb.data = DATA_W_MAX'(sel.data[DATA_W-1:0]);
    end

endmodule

`default_nettype wire

/* sb_core.sv */
`timescale 1ns/10ps
`default_nettype none

module sb_core import sb_pkg::*; #(
    parameter int DATA_W     = 32,
    parameter int MUL_CYCLES = 4
) (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               instr_valid,
    input  logic [INSTR_W-1:0] instr,
    output logic               stall,
    output logic               res_valid,
    output reg_idx_t           res_rd,
    output logic [DATA_W-1:0]  res_data
);

    decoded_t          dec;
    reg_status_t       st_rd;
    reg_status_t       st_rs1;
    reg_status_t       st_rs2;
    logic              alu_busy;
    logic              mul_busy;
    logic              alu_issue;
    logic              mul_issue;
    fu_req_t           req;
    logic              set_en;
    reg_idx_t          set_rd;
    fu_t               set_tag;
    wb_t               alu_res;
    wb_t               mul_res;
    logic              alu_ack;
    logic              mul_ack;
    wb_t               wb;
    // read ports 0/1 serve the ALU row, 2/3 the multiplier row
    reg_idx_t          rf_raddr [4];
    logic [DATA_W-1:0] rf_rdata [4];

    sb_decode u_decode (
        .instr (instr),
        .dec   (dec)
    );

    sb_dispatch #(.DATA_W(DATA_W)) u_dispatch (
        .instr_valid (instr_valid),
        .dec         (dec),
        .st_rd       (st_rd),
        .st_rs1      (st_rs1),
        .st_rs2      (st_rs2),
        .alu_busy    (alu_busy),
        .mul_busy    (mul_busy),
        .stall       (stall),
        .alu_issue   (alu_issue),
        .mul_issue   (mul_issue),
        .req         (req),
        .set_en      (set_en),
        .set_rd      (set_rd),
        .set_tag     (set_tag)
    );

    sb_reg_status u_reg_status (
        .CLK     (CLK),
        .nRST    (nRST),
        .set_en  (set_en),
        .set_rd  (set_rd),
        .set_tag (set_tag),
        .wb      (wb),
        .rd      (dec.rd),
        .rs1     (dec.rs1),
        .rs2     (dec.rs2),
        .st_rd   (st_rd),
        .st_rs1  (st_rs1),
        .st_rs2  (st_rs2)
    );

    sb_fu_alu #(.DATA_W(DATA_W)) u_fu_alu (
        .CLK    (CLK),
        .nRST   (nRST),
        .issue  (alu_issue),
        .req    (req),
        .wb     (wb),
        .ack    (alu_ack),
        .op_a   (rf_rdata[0]),
        .op_b   (rf_rdata[1]),
        .rs1    (rf_raddr[0]),
        .rs2    (rf_raddr[1]),
        .busy   (alu_busy),
        .result (alu_res)
    );

    sb_fu_mul #(.DATA_W(DATA_W), .MUL_CYCLES(MUL_CYCLES)) u_fu_mul (
        .CLK    (CLK),
        .nRST   (nRST),
        .issue  (mul_issue),
        .req    (req),
        .wb     (wb),
        .ack    (mul_ack),
        .op_a   (rf_rdata[2]),
        .op_b   (rf_rdata[3]),
        .rs1    (rf_raddr[2]),
        .rs2    (rf_raddr[3]),
        .busy   (mul_busy),
        .result (mul_res)
    );

    sb_regfile #(.DATA_W(DATA_W)) u_regfile (
        .CLK   (CLK),
        .nRST  (nRST),
        .raddr (rf_raddr),
        .rdata (rf_rdata),
        .wb    (wb)
    );

    sb_writeback #(.DATA_W(DATA_W)) u_writeback (
        .alu_res (alu_res),
        .mul_res (mul_res),
        .alu_ack (alu_ack),
        .mul_ack (mul_ack),
        .wb      (wb)
    );

    assign res_valid = wb.en;
    assign res_rd    = wb.rd;
    assign res_data  = wb.data[DATA_W-1:0];

endmodule

`default_nettype wire

/* sb_core_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module sb_core_assertions import sb_pkg::*; (
    input wire logic     CLK,
    input wire logic     nRST,
    input wire logic     instr_valid,
    input wire logic     stall,
    input wire logic     alu_issue,
    input wire logic     mul_issue,
    input wire logic     alu_busy,
    input wire logic     mul_busy,
    input wire logic     res_valid,
    input wire reg_idx_t res_rd,
    input wire logic     alu_ack,
    input wire logic     mul_ack,
    input wire logic     alu_res_en,
    input wire logic     mul_res_en
);

    // a unit holds a single row
    a_alu_issue_free: assert property (@(posedge CLK) disable iff (!nRST)
        alu_issue |-> !alu_busy) else $error("ALU issued while busy");
    a_mul_issue_free: assert property (@(posedge CLK) disable iff (!nRST)
        mul_issue |-> !mul_busy) else $error("multiplier issued while busy");

    a_stall_needs_valid: assert property (@(posedge CLK) disable iff (!nRST)
        stall |-> instr_valid) else $error("stall without instr_valid");

    // r0 is never written
    a_no_r0_result: assert property (@(posedge CLK) disable iff (!nRST)
        res_valid |-> (res_rd != '0)) else $error("result reported for r0");

    // an acknowledged unit had a result on offer and frees its row at the next edge
    a_alu_ack_offer: assert property (@(posedge CLK) disable iff (!nRST)
        alu_ack |-> alu_res_en ##1 !alu_busy)
        else $error("ALU acknowledged without a result or not released");
    a_mul_ack_offer: assert property (@(posedge CLK) disable iff (!nRST)
        mul_ack |-> mul_res_en ##1 !mul_busy)
        else $error("multiplier acknowledged without a result or not released");

endmodule

bind sb_core sb_core_assertions u_sb_core_assertions (
    .CLK         (CLK),
    .nRST        (nRST),
    .instr_valid (instr_valid),
    .stall       (stall),
    .alu_issue   (alu_issue),
    .mul_issue   (mul_issue),
    .alu_busy    (alu_busy),
    .mul_busy    (mul_busy),
    .res_valid   (res_valid),
    .res_rd      (res_rd),
    .alu_ack     (alu_ack),
    .mul_ack     (mul_ack),
    .alu_res_en  (alu_res.en),
    .mul_res_en  (mul_res.en)
);

`default_nettype wire

/* sb_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module sb_core_tb import sb_pkg::*; ();

    localparam int DATA_W       = 32;
    localparam int MUL_CYCLES   = 4;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    // upper bound on instructions sent by all tests together
    localparam int NUM_INSTR    = 240;
    localparam int WATCHDOG_NS  =
        (NUM_INSTR * (MUL_CYCLES + 6) + RESET_CYCLES) * CLK_PERIOD;

    logic              CLK;
    logic              nRST;
    logic              instr_valid;
    logic [31:0]       instr;
    logic              stall;
    logic              res_valid;
    reg_idx_t          res_rd;
    logic [DATA_W-1:0] res_data;

    // reference model state
    logic [31:0] model_regs [NUM_REGS];
    logic [31:0] pend_val [NUM_REGS];
    logic        pend_valid [NUM_REGS];
    int          outstanding;
    int          writes_expected;
    int          writes_seen;
    int          stall_cycles;
    int          errors;
    int          err_mark;
    int          tests_run;
    logic [31:0] lfsr_state;

    sb_core #(.DATA_W(DATA_W), .MUL_CYCLES(MUL_CYCLES)) u_sb_core (
        .CLK         (CLK),
        .nRST        (nRST),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stall       (stall),
        .res_valid   (res_valid),
        .res_rd      (res_rd),
        .res_data    (res_data)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired with %0d results still outstanding", outstanding);
        $display("TEST FAIL");
        $finish;
    end

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_take(input int nbits);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < nbits; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return bits;
    endfunction

    function automatic logic [31:0] enc(input opcode_t op, input int rd, input int rs1,
                                        input int rs2, input logic [15:0] imm);
        return {op, 4'(rd), 4'(rs1), 4'(rs2), imm};
    endfunction

    // arithmetic as the instruction set defines it
    function automatic logic [31:0] model_result(input opcode_t op, input logic [31:0] a,
                                                 input logic [31:0] b,
                                                 input logic [15:0] imm);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_ADDI: return a + {{16{imm[15]}}, imm};
            OP_MUL:  return a * b;
            default: return '0;
        endcase
    endfunction

    // applied in program order at the cycle the DUT takes the word
    task automatic accept_model(input logic [31:0] word);
        opcode_t     op;
        int          rd;
        logic [31:0] val;
        op = (word[31:28] > 4'(OP_MUL)) ? OP_NOP : opcode_t'(word[31:28]);
        rd = word[27:24];
        if ((op != OP_NOP) && (rd != 0)) begin
            val = model_result(op, model_regs[word[23:20]], model_regs[word[19:16]],
                               word[15:0]);
            if (pend_valid[rd]) begin
                errors++;
                $display("write to r%0d accepted while an older write is outstanding", rd);
            end
            model_regs[rd] = val;
            pend_val[rd]   = val;
            pend_valid[rd] = 1'b1;
            outstanding++;
            writes_expected++;
        end
    endtask

    // retire before accept so a same-cycle retire and claim of one register stay in order
    always @(negedge CLK) begin
        if (nRST) begin
            if (stall) begin
                stall_cycles++;
            end
            if (res_valid) begin
                writes_seen++;
                if (!pend_valid[res_rd]) begin
                    errors++;
                    $display("result on r%0d with no write outstanding", res_rd);
                end else begin
                    check_eq($sformatf("res_data r%0d", res_rd), res_data, pend_val[res_rd]);
                    pend_valid[res_rd] = 1'b0;
                    outstanding--;
                end
            end
            if (instr_valid && !stall) begin
                accept_model(instr);
            end
        end
    end

    // called on a rising edge and returns on the edge that takes the word
    task automatic send(input logic [31:0] word, output int waits);
        waits = 0;
        instr_valid <= 1'b1;
        instr       <= word;
        @(negedge CLK);
        while (stall) begin
            waits++;
            @(negedge CLK);
        end
        @(posedge CLK);
    endtask

    task automatic drain();
        instr_valid <= 1'b0;
        wait (outstanding == 0);
        // idle tail so a stray result still shows up in the monitor
        repeat (MUL_CYCLES + 2) @(posedge CLK);
    endtask

    task automatic report_test(input string name);
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
        err_mark = errors;
    endtask

    task automatic after_reset();
        int waits;
        @(negedge CLK);
        check_eq("stall", stall, 1'b0);
        check_eq("res_valid", res_valid, 1'b0);
        @(posedge CLK);
        send(enc(OP_ADDI, 1, 0, 0, 16'h1234), waits);
        check_eq("first stall cycles", waits, 0);
        drain();
        report_test("reset state");
    endtask

    task automatic alu_ops();
        int waits;
        send(enc(OP_ADDI, 1, 0, 0, 16'h0013), waits);
        send(enc(OP_ADDI, 2, 0, 0, 16'hfff0), waits);
        send(enc(OP_ADD, 3, 1, 2, 16'h0), waits);
        send(enc(OP_SUB, 4, 1, 2, 16'h0), waits);
        send(enc(OP_XOR, 5, 1, 2, 16'h0), waits);
        send(enc(OP_SLL, 6, 1, 2, 16'h0), waits);
        send(enc(OP_AND, 7, 1, 2, 16'h0), waits);
        send(enc(OP_OR, 8, 2, 1, 16'h0), waits);
        drain();
        report_test("alu ops");
    endtask

    task automatic raw_chain();
        int waits;
        send(enc(OP_ADDI, 3, 0, 0, 16'h0007), waits);
        send(enc(OP_MUL, 4, 3, 3, 16'h0), waits);
        send(enc(OP_ADD, 5, 4, 3, 16'h0), waits);
        drain();
        report_test("raw chain");
    endtask

    task automatic stall_hazards();
        int waits;
        int seen0;
        int stalls0;
        seen0   = writes_seen;
        stalls0 = stall_cycles;
        send(enc(OP_MUL, 9, 1, 2, 16'h0), waits);
        send(enc(OP_MUL, 10, 9, 1, 16'h0), waits);
        // r10 still owned by the multiplier
        send(enc(OP_ADD, 10, 1, 1, 16'h0), waits);
        send(enc(OP_MUL, 11, 10, 10, 16'h0), waits);
        drain();
        check_eq("stall seen", (stall_cycles > stalls0), 1'b1);
        check_eq("res_valid count", writes_seen - seen0, 4);
        report_test("hazards");
    endtask

    task automatic no_write_ops();
        int waits;
        int seen0;
        seen0 = writes_seen;
        send(32'h0000_0000, waits);
        send(32'hf123_4567, waits);
        send(32'hc0ff_ee00, waits);
        send(enc(OP_ADD, 0, 1, 2, 16'h0), waits);
        send(enc(OP_MUL, 0, 1, 2, 16'h0), waits);
        send(enc(OP_ADDI, 0, 0, 0, 16'h0005), waits);
        send(enc(OP_ADD, 12, 0, 1, 16'h0), waits);
        send(enc(OP_ADDI, 13, 0, 0, 16'h7fff), waits);
        drain();
        check_eq("res_valid count", writes_seen - seen0, 2);
        report_test("no write");
    endtask

    task automatic random_stream();
        int          waits;
        int          seen0;
        int          exp0;
        logic [31:0] word;
        seen0 = writes_seen;
        exp0  = writes_expected;
        for (int n = 0; n < 200; n++) begin
            word = lfsr_take(32);
            send(word, waits);
        end
        drain();
        check_eq("res_valid count", writes_seen - seen0, writes_expected - exp0);
        report_test("random stream");
    endtask

    initial begin
        nRST            = 1'b0;
        instr_valid     = 1'b0;
        instr           = '0;
        outstanding     = 0;
        writes_expected = 0;
        writes_seen     = 0;
        stall_cycles    = 0;
        errors          = 0;
        err_mark        = 0;
        tests_run       = 0;
        lfsr_state      = 32'hbfae_79df;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
            pend_val[i]   = '0;
            pend_valid[i] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;

        after_reset();
        alu_ops();
        raw_chain();
        stall_hazards();
        no_write_ops();
        random_stream();

        check_eq("total res_valid count", writes_seen, writes_expected);
        $display("tests %0d, results %0d, stall cycles %0d, errors %0d",
                 tests_run, writes_seen, stall_cycles, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sb_core.f */
sb_pkg.sv
sb_decode.sv
sb_reg_status.sv
sb_dispatch.sv
sb_fu_alu.sv
sb_fu_mul.sv
sb_regfile.sv
sb_writeback.sv
sb_core.sv
sb_core_assertions.sv
sb_core_tb.sv
